// File: circle_draw.f
+incdir+src
src/circle_pkg.sv
src/circle_datapath.sv
src/circle_control.sv
src/screen_clear.sv
src/circle_draw.sv
tests/circle_draw_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the circle renderer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f circle_draw.f \
    --top-module circle_draw_tb \
    --Mdir obj_dir \
    -o circle_draw_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/circle_draw_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

exit 0

// File: src/circle_control.sv
`default_nettype none
`include "circle_settings.svh"

module circle_control (
    input  wire logic                        clk,
    input  wire logic                        resetn,

    input  wire logic                        start,
    input  wire logic                        clear,

    input  wire logic signed [`COORD_DW-1:0] offset_x,
    input  wire logic signed [`COORD_DW-1:0] offset_y,
    input  wire logic signed [`COORD_DW:0]   crit,
    input  wire logic                        clear_done,

    output logic                             clear_go,
    output logic                             clearing,
    output circle_pkg::octant_e              octant_sel,
    output logic                             draw_en,
    output logic                             dec_x,
    output logic                             inc_y,
    output logic                             calc_crit,
    output logic                             load_init,
    output logic                             load_next,
    output logic                             load_crit,
    output logic                             done
);

    circle_pkg::ctrl_state_e state, state_nxt;
    circle_pkg::octant_e     oct_q;
    logic                    dec_q;

    // Offsets as they will be after the load cycle
    logic signed [`COORD_DW-1:0] next_x;
    logic signed [`COORD_DW-1:0] next_y;
    logic                        more;

    assign next_y = offset_y + 1;
    assign next_x = dec_q ? offset_x - 1 : offset_x;
    assign more   = (next_y <= next_x);

    always_comb begin
        state_nxt = state;
        case (state)
            circle_pkg::IDLE:  if (start) state_nxt = clear ? circle_pkg::CLEAR : circle_pkg::INIT;
            circle_pkg::CLEAR: if (clear_done) state_nxt = circle_pkg::INIT;
            circle_pkg::INIT:  state_nxt = circle_pkg::DRAW;
            circle_pkg::DRAW:  if (oct_q == circle_pkg::OCT7) state_nxt = circle_pkg::STEP;
            circle_pkg::STEP:  state_nxt = circle_pkg::CRIT;
            circle_pkg::CRIT:  state_nxt = circle_pkg::LOAD;
            circle_pkg::LOAD:  state_nxt = more ? circle_pkg::DRAW : circle_pkg::DONE;
            default:           state_nxt = circle_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= circle_pkg::IDLE;
            oct_q    <= circle_pkg::OCT0;
            dec_q    <= 1'b0;
            clear_go <= 1'b0;
        end else begin
            state    <= state_nxt;
            clear_go <= (state == circle_pkg::IDLE) && start && clear;
            if (state == circle_pkg::DRAW) begin
                oct_q <= oct_q.next();
            end else begin
                oct_q <= circle_pkg::OCT0;
            end
            if (state == circle_pkg::STEP) begin
                dec_q <= dec_x;
            end
        end
    end

    assign clearing   = (state == circle_pkg::CLEAR);
    assign octant_sel = oct_q;
    assign draw_en    = (state == circle_pkg::DRAW);
    assign load_init  = (state == circle_pkg::INIT);
    assign load_crit  = (state == circle_pkg::INIT);
    // x moves inward only while the midpoint lies outside the circle
    assign inc_y      = (state == circle_pkg::STEP);
    assign dec_x      = (state == circle_pkg::STEP) && (crit > 0);
    assign calc_crit  = (state == circle_pkg::CRIT);
    assign load_next  = (state == circle_pkg::LOAD);
    assign done       = (state == circle_pkg::DONE);

    // Drawing stays in the first octant with y from 0 up to x
    a_draw_in_octant: assert property (@(posedge clk) disable iff (!resetn)
        draw_en |-> (offset_y >= 0) && (offset_y <= offset_x));

    // The loop only ends once the loaded y has passed x
    a_done_past_x: assert property (@(posedge clk) disable iff (!resetn)
        done |-> (offset_y > offset_x));

endmodule

`default_nettype wire

// File: src/circle_datapath.sv
`default_nettype none
`include "circle_settings.svh"

module circle_datapath (
    input  wire logic                         clk,
    input  wire logic                         resetn,

    input  wire logic signed [`COORD_DW-1:0]  centre_x,
    input  wire logic signed [`COORD_DW-1:0]  centre_y,
    input  wire logic signed [`RADIUS_DW-1:0] radius,

    input  wire circle_pkg::octant_e          octant_sel,
    input  wire logic                         draw_en,
    input  wire logic                         dec_x,
    input  wire logic                         inc_y,
    input  wire logic                         calc_crit,
    input  wire logic                         load_init,
    input  wire logic                         load_next,
    input  wire logic                         load_crit,

    output logic signed [`COORD_DW-1:0]       offset_x,
    output logic signed [`COORD_DW-1:0]       offset_y,
    output logic signed [`COORD_DW:0]         crit,

    output logic [`VGA_X_DW-1:0]              circ_x,
    output logic [`VGA_Y_DW-1:0]              circ_y,
    output logic                              circ_plot
);

    logic signed [`COORD_DW-1:0] calc_x;
    logic signed [`COORD_DW-1:0] calc_y;
    logic                        dec_q;

    logic signed [`COORD_DW-1:0] y_minus_x;
    logic signed [`COORD_DW:0]   crit_delta;

    // Operands widened by one bit so centre plus offset cannot wrap
    logic signed [`COORD_DW:0] cx_w, cy_w, ox_w, oy_w;
    logic signed [`COORD_DW:0] cx_plus_ox, cx_minus_ox, cx_plus_oy, cx_minus_oy;
    logic signed [`COORD_DW:0] cy_plus_ox, cy_minus_ox, cy_plus_oy, cy_minus_oy;
    logic signed [`COORD_DW:0] pt_x, pt_y;
    logic                      on_x, on_y;

    // Plotted point measured back from the centre
    logic signed [`COORD_DW:0] dist_x, dist_y;
    logic signed [`COORD_DW:0] abs_x, abs_y;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            offset_x <= '0;
            offset_y <= '0;
        end else if (load_init) begin
            offset_x <= `COORD_DW'(radius);
            offset_y <= '0;
        end else if (load_next) begin
            offset_x <= calc_x;
            offset_y <= calc_y;
        end
    end

    // Next offsets and the x decision are staged in the step cycle
    always_ff @(posedge clk) begin
        if (inc_y) begin
            calc_y <= offset_y + 1;
            calc_x <= dec_x ? offset_x - 1 : offset_x;
            dec_q  <= dec_x;
        end
    end

    // 2*y for a pure y step and 2*(y - x) when x also moved
    assign y_minus_x  = calc_y - calc_x;
    assign crit_delta = dec_q ? {y_minus_x, 1'b0} : {calc_y, 1'b0};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crit <= '0;
        end else if (load_crit) begin
            crit <= 1 - radius;
        end else if (calc_crit) begin
            crit <= crit + crit_delta + 1;
        end
    end

    assign cx_w = {centre_x[`COORD_DW-1], centre_x};
    assign cy_w = {centre_y[`COORD_DW-1], centre_y};
    assign ox_w = {offset_x[`COORD_DW-1], offset_x};
    assign oy_w = {offset_y[`COORD_DW-1], offset_y};

    // Eight unique sums cover all octant points
    assign cx_plus_ox  = cx_w + ox_w;
    assign cx_minus_ox = cx_w - ox_w;
    assign cx_plus_oy  = cx_w + oy_w;
    assign cx_minus_oy = cx_w - oy_w;
    assign cy_plus_ox  = cy_w + ox_w;
    assign cy_minus_ox = cy_w - ox_w;
    assign cy_plus_oy  = cy_w + oy_w;
    assign cy_minus_oy = cy_w - oy_w;

    always_comb begin
        case (octant_sel)
            circle_pkg::OCT0: begin
                pt_x = cx_plus_ox;
                pt_y = cy_plus_oy;
            end
            circle_pkg::OCT1: begin
                pt_x = cx_plus_oy;
                pt_y = cy_plus_ox;
            end
            circle_pkg::OCT2: begin
                pt_x = cx_minus_oy;
                pt_y = cy_plus_ox;
            end
            circle_pkg::OCT3: begin
                pt_x = cx_minus_ox;
                pt_y = cy_plus_oy;
            end
            circle_pkg::OCT4: begin
                pt_x = cx_minus_ox;
                pt_y = cy_minus_oy;
            end
            circle_pkg::OCT5: begin
                pt_x = cx_minus_oy;
                pt_y = cy_minus_ox;
            end
            circle_pkg::OCT6: begin
                pt_x = cx_plus_oy;
                pt_y = cy_minus_ox;
            end
            default: begin
                pt_x = cx_plus_ox;
                pt_y = cy_minus_oy;
            end
        endcase
    end

    // Off-screen points are dropped but still cost their draw cycle
    assign on_x = (pt_x >= 0) && (pt_x < `SCREEN_W);
    assign on_y = (pt_y >= 0) && (pt_y < `SCREEN_H);

    assign circ_x    = on_x ? pt_x[`VGA_X_DW-1:0] : '0;
    assign circ_y    = on_y ? pt_y[`VGA_Y_DW-1:0] : '0;
    assign circ_plot = draw_en && on_x && on_y;

    assign dist_x = $signed({1'b0, circ_x}) - cx_w;
    assign dist_y = $signed({1'b0, circ_y}) - cy_w;
    assign abs_x  = (dist_x < 0) ? -dist_x : dist_x;
    assign abs_y  = (dist_y < 0) ? -dist_y : dist_y;

    // A plotted point lies on screen at one of the eight reflections of the offsets
    a_plot_on_circle: assert property (@(posedge clk) disable iff (!resetn)
        circ_plot |-> (circ_x < `SCREEN_W) && (circ_y < `SCREEN_H)
            && (((abs_x == ox_w) && (abs_y == oy_w)) || ((abs_x == oy_w) && (abs_y == ox_w))));

endmodule

`default_nettype wire

// File: src/circle_draw.sv
`default_nettype none
`include "circle_settings.svh"

module circle_draw (
    input  wire logic                         clk,
    input  wire logic                         resetn,

    input  wire logic                         start,
    input  wire logic                         clear,
    input  wire logic signed [`COORD_DW-1:0]  centre_x,
    input  wire logic signed [`COORD_DW-1:0]  centre_y,
    input  wire logic signed [`RADIUS_DW-1:0] radius,
    input  wire logic [`COLOUR_DW-1:0]        colour,

    output logic [`VGA_X_DW-1:0]              vga_x,
    output logic [`VGA_Y_DW-1:0]              vga_y,
    output logic [`COLOUR_DW-1:0]             vga_colour,
    output logic                              plot,
    output logic                              done
);

    logic busy;
    logic take;

    logic signed [`COORD_DW-1:0]  cx_q;
    logic signed [`COORD_DW-1:0]  cy_q;
    logic signed [`RADIUS_DW-1:0] radius_q;
    logic [`COLOUR_DW-1:0]        colour_q;

    logic                        clear_go, clearing, clear_done;
    circle_pkg::octant_e         octant_sel;
    logic                        draw_en, dec_x, inc_y, calc_crit;
    logic                        load_init, load_next, load_crit;
    logic signed [`COORD_DW-1:0] offset_x, offset_y;
    logic signed [`COORD_DW:0]   crit;

    logic [`VGA_X_DW-1:0] circ_x, clr_x;
    logic [`VGA_Y_DW-1:0] circ_y, clr_y;
    logic                 circ_plot, clr_plot;

    // Mirrors the controller being out of IDLE, so a busy start leaves inputs alone
    assign take = start && !busy;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cx_q     <= centre_x;
            cy_q     <= centre_y;
            radius_q <= radius;
            colour_q <= colour;
        end
    end

    circle_control u_control (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .clear      (clear),
        .offset_x   (offset_x),
        .offset_y   (offset_y),
        .crit       (crit),
        .clear_done (clear_done),
        .clear_go   (clear_go),
        .clearing   (clearing),
        .octant_sel (octant_sel),
        .draw_en    (draw_en),
        .dec_x      (dec_x),
        .inc_y      (inc_y),
        .calc_crit  (calc_crit),
        .load_init  (load_init),
        .load_next  (load_next),
        .load_crit  (load_crit),
        .done       (done)
    );

    circle_datapath u_datapath (
        .clk        (clk),
        .resetn     (resetn),
        .centre_x   (cx_q),
        .centre_y   (cy_q),
        .radius     (radius_q),
        .octant_sel (octant_sel),
        .draw_en    (draw_en),
        .dec_x      (dec_x),
        .inc_y      (inc_y),
        .calc_crit  (calc_crit),
        .load_init  (load_init),
        .load_next  (load_next),
        .load_crit  (load_crit),
        .offset_x   (offset_x),
        .offset_y   (offset_y),
        .crit       (crit),
        .circ_x     (circ_x),
        .circ_y     (circ_y),
        .circ_plot  (circ_plot)
    );

    screen_clear u_clear (
        .clk        (clk),
        .resetn     (resetn),
        .clear_go   (clear_go),
        .clr_x      (clr_x),
        .clr_y      (clr_y),
        .clr_plot   (clr_plot),
        .clear_done (clear_done)
    );

    // Clear sweep owns the pixel port while it runs, always writing black
    assign vga_x      = clearing ? clr_x : circ_x;
    assign vga_y      = clearing ? clr_y : circ_y;
    assign vga_colour = clearing ? '0 : colour_q;
    assign plot       = clearing ? clr_plot : circ_plot;

endmodule

`default_nettype wire

// File: src/circle_pkg.sv
`default_nettype none

package circle_pkg;

    // Controller phases
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        INIT,
        DRAW,
        STEP,
        CRIT,
        LOAD,
        DONE
    } ctrl_state_e;

    // One symmetric point per octant
    typedef enum logic [2:0] {
        OCT0, OCT1, OCT2, OCT3, OCT4, OCT5, OCT6, OCT7
    } octant_e;

endpackage

`default_nettype wire

// File: src/circle_settings.svh
`ifndef CIRCLE_SETTINGS_SVH
`define CIRCLE_SETTINGS_SVH

// Frame buffer geometry
`define SCREEN_W 160
`define SCREEN_H 120

// Unsigned screen coordinates
`define VGA_X_DW 8
`define VGA_Y_DW 7

// Signed centre and offset arithmetic
`define COORD_DW 10
`define RADIUS_DW 9

// 3-bit RGB colour
`define COLOUR_DW 3

`endif

// File: src/screen_clear.sv
`default_nettype none
`include "circle_settings.svh"

module screen_clear (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            clear_go,

    output logic [`VGA_X_DW-1:0] clr_x,
    output logic [`VGA_Y_DW-1:0] clr_y,
    output logic                 clr_plot,
    output logic                 clear_done
);

    localparam logic [`VGA_X_DW-1:0] X_LAST = `VGA_X_DW'(`SCREEN_W - 1);
    localparam logic [`VGA_Y_DW-1:0] Y_LAST = `VGA_Y_DW'(`SCREEN_H - 1);

    logic active;
    logic last_px;

    assign last_px = (clr_x == X_LAST) && (clr_y == Y_LAST);

    // Raster order, x fastest
    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
            clr_x  <= '0;
            clr_y  <= '0;
        end else if (clear_go) begin
            active <= 1'b1;
            clr_x  <= '0;
            clr_y  <= '0;
        end else if (active) begin
            if (clr_x == X_LAST) begin
                clr_x <= '0;
                clr_y <= last_px ? '0 : clr_y + 1;
                if (last_px) begin
                    active <= 1'b0;
                end
            end else begin
                clr_x <= clr_x + 1;
            end
        end
    end

    assign clr_plot   = active;
    assign clear_done = active && last_px;

    a_x_in_range: assert property (@(posedge clk) disable iff (!resetn)
        clr_x < `SCREEN_W);

endmodule

`default_nettype wire

// File: tests/circle_draw_tb.sv
`default_nettype none
`include "circle_settings.svh"

module circle_draw_tb;

    localparam int NROWS      = 11;
    localparam int CLEAR_PX   = `SCREEN_W * `SCREEN_H;
    localparam int MAX_CYCLES = 40000;

    logic                         clk;
    logic                         resetn;
    logic                         start;
    logic                         clear;
    logic signed [`COORD_DW-1:0]  centre_x;
    logic signed [`COORD_DW-1:0]  centre_y;
    logic signed [`RADIUS_DW-1:0] radius;
    logic [`COLOUR_DW-1:0]        colour;
    logic [`VGA_X_DW-1:0]         vga_x;
    logic [`VGA_Y_DW-1:0]         vga_y;
    logic [`COLOUR_DW-1:0]        vga_colour;
    logic                         plot;
    logic                         done;

    // Columns: centre x, centre y, radius, colour (-1 picks a random one), clear
    int tbl [NROWS][5] = '{
        '{  80,  60,  30,  1, 1},
        '{  80,  60,  59, -1, 0},
        '{  20,  60,  35,  2, 0},
        '{ 150,  50,  25, -1, 0},
        '{  70,   5,  20,  4, 0},
        '{  90, 115,  18,  5, 0},
        '{   0,   0,  50,  6, 0},
        '{ 100,  40,   0,  7, 0},
        '{ -60, 200,  40,  3, 0},
        '{ 159, 119, 120, -1, 0},
        '{  80,  60, 200,  2, 0}
    };

    // Expected and observed frame contents of one circle
    bit exp_map [`SCREEN_W][`SCREEN_H];
    bit obs_map [`SCREEN_W][`SCREEN_H];
    int exp_plots;
    int exp_iters;
    bit exp_last_full;

    circle_draw dut (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .clear      (clear),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .radius     (radius),
        .colour     (colour),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .plot       (plot),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, expected);
            fail_run("Value mismatch");
        end
    endtask

    // Midpoint circle rule, marking every on-screen reflection
    task automatic model_circle(input int cx, input int cy, input int r);
        int x;
        int y;
        int d;
        int k;
        int px;
        int py;
        int hits;
        foreach (exp_map[i, j]) exp_map[i][j] = 1'b0;
        exp_plots = 0;
        exp_iters = 0;
        x = r;
        y = 0;
        d = 1 - r;
        do begin
            hits = 0;
            for (k = 0; k < 8; k++) begin
                px = k[2] ? y : x;
                py = k[2] ? x : y;
                if (k[0]) px = -px;
                if (k[1]) py = -py;
                px = cx + px;
                py = cy + py;
                if (px >= 0 && px < `SCREEN_W && py >= 0 && py < `SCREEN_H) begin
                    exp_map[px][py] = 1'b1;
                    hits++;
                end
            end
            exp_plots += hits;
            exp_last_full = (hits == 8);
            exp_iters++;
            y++;
            if (d > 0) begin
                x--;
                d += 2 * (y - x) + 1;
            end else begin
                d += 2 * y + 1;
            end
        end while (y <= x);
    endtask

    task automatic run_row(input int cx, input int cy, input int r, input int col,
                           input int clr, input int poke_at);
        int cyc;
        int nplot;
        int last_plot;
        int done_cyc;
        int lat;
        model_circle(cx, cy, r);
        foreach (obs_map[i, j]) obs_map[i][j] = 1'b0;
        @(negedge clk);
        centre_x = cx;
        centre_y = cy;
        radius   = r;
        colour   = col;
        clear    = clr;
        start    = 1'b1;
        @(negedge clk);
        // Inputs change after start, the run must keep the latched values
        start    = 1'b0;
        clear    = 1'b0;
        centre_x = '0;
        centre_y = '0;
        radius   = '0;
        colour   = '0;
        cyc       = 1;
        nplot     = 0;
        last_plot = 0;
        done_cyc  = 0;
        while (done_cyc == 0) begin
            if (plot) begin
                if (clr != 0 && nplot < CLEAR_PX) begin
                    compare_value("vga_x", vga_x, nplot % `SCREEN_W);
                    compare_value("vga_y", vga_y, nplot / `SCREEN_W);
                    compare_value("vga_colour", vga_colour, 0);
                end else if (vga_x >= `SCREEN_W || vga_y >= `SCREEN_H) begin
                    fail_run($sformatf("Pixel written off screen at %0d,%0d", vga_x, vga_y));
                end else begin
                    compare_value("vga_colour", vga_colour, col);
                    obs_map[vga_x][vga_y] = 1'b1;
                    last_plot = cyc;
                end
                nplot++;
            end
            if (done) done_cyc = cyc;
            // A second start in mid run must be ignored
            start = (cyc == poke_at);
            if (start) begin
                centre_x = cx + 9;
                radius   = r + 5;
                colour   = ~col;
                clear    = 1'b1;
            end
            if (done_cyc == 0) begin
                if (cyc >= MAX_CYCLES) begin
                    fail_run("Timed out waiting for the done pulse");
                end else begin
                    @(negedge clk);
                    cyc++;
                end
            end
        end
        start = 1'b0;
        clear = 1'b0;
        // Only one done pulse and no stray writes afterwards
        repeat (12) begin
            @(negedge clk);
            compare_value("done", done, 0);
            compare_value("plot", plot, 0);
        end
        lat = (clr != 0) ? CLEAR_PX + 3 + 11 * exp_iters : 2 + 11 * exp_iters;
        compare_value("plot count", nplot, ((clr != 0) ? CLEAR_PX : 0) + exp_plots);
        compare_value("done cycle", done_cyc, lat);
        if (exp_last_full) begin
            compare_value("cycles from last plot to done", done_cyc - last_plot, 4);
        end
        foreach (exp_map[i, j]) begin
            if (obs_map[i][j] != exp_map[i][j]) begin
                compare_value($sformatf("pixel %0d,%0d", i, j), obs_map[i][j], exp_map[i][j]);
            end
        end
    endtask

    initial begin
        int col;
        void'($urandom(32'h2e3716ae));
        resetn   = 1'b0;
        start    = 1'b0;
        clear    = 1'b0;
        centre_x = '0;
        centre_y = '0;
        radius   = '0;
        colour   = '0;
        repeat (10) begin
            @(negedge clk);
            compare_value("plot", plot, 0);
            compare_value("done", done, 0);
        end
        resetn = 1'b1;
        @(negedge clk);
        compare_value("plot", plot, 0);
        compare_value("done", done, 0);

        for (int i = 0; i < NROWS; i++) begin
            col = (tbl[i][3] < 0) ? $urandom_range(7, 0) : tbl[i][3];
            run_row(tbl[i][0], tbl[i][1], tbl[i][2], col, tbl[i][4], 0);
        end
        // Busy start arrives during the draw phase
        run_row(60, 60, 45, 5, 0, 40);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
